/* source/mem_pipe_pkg.sv */
`default_nettype none

package mem_pipe_pkg;

    localparam int unsigned data_width = 32;

    // decoded instruction as it enters the execute stage
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_ld_b   = 4'd1,
        op_ld_bu  = 4'd2,
        op_ld_h   = 4'd3,
        op_ld_hu  = 4'd4,
        op_ld_w   = 4'd5,
        op_st_w   = 4'd6,
        op_mul_lo = 4'd7,
        op_mul_hi = 4'd8
    } exe_op_e;

    // width and sign of a load, resolved in the memory stage
    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_b    = 3'd1,
        ld_bu   = 3'd2,
        ld_h    = 3'd3,
        ld_hu   = 3'd4,
        ld_w    = 3'd5
    } load_kind_e;

    // source of the value written back to the register file
    typedef enum logic [1:0] {
        src_alu    = 2'd0,
        src_mem    = 2'd1,
        src_mul_lo = 2'd2,
        src_mul_hi = 2'd3
    } result_src_e;

endpackage

`default_nettype wire

/* source/exe_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_stage #(
    parameter int ram_addr_width = 8
) (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  in_valid,
    input  mem_pipe_pkg::exe_op_e                 in_op,
    input  logic [mem_pipe_pkg::data_width-1:0]   in_pc,
    input  logic [4:0]                            in_rd,
    input  logic [mem_pipe_pkg::data_width-1:0]   in_src1,
    input  logic [mem_pipe_pkg::data_width-1:0]   in_src2,
    input  logic [mem_pipe_pkg::data_width-1:0]   in_imm,
    output logic                                  in_allowin,
    input  logic                                  mem_allowin,
    output logic                                  exe_to_mem_valid,
    output logic [mem_pipe_pkg::data_width-1:0]   exe_pc,
    output logic [4:0]                            exe_rd,
    output logic                                  exe_we,
    output logic [mem_pipe_pkg::data_width-1:0]   exe_alu_result,
    output mem_pipe_pkg::load_kind_e              exe_load_kind,
    output mem_pipe_pkg::result_src_e             exe_result_src,
    output logic                                  ram_en,
    output logic                                  ram_we,
    output logic [ram_addr_width-1:0]             ram_addr,
    output logic [mem_pipe_pkg::data_width-1:0]   ram_wdata,
    output logic                                  mul_en,
    output logic [mem_pipe_pkg::data_width-1:0]   mul_a,
    output logic [mem_pipe_pkg::data_width-1:0]   mul_b
);
    import mem_pipe_pkg::*;

    logic                  exe_valid;
    exe_op_e               op_r;
    logic [data_width-1:0] src1_r;
    logic [data_width-1:0] src2_r;
    logic [data_width-1:0] imm_r;
    logic [data_width-1:0] sum;
    logic [data_width-1:0] addr;
    logic                  exe_go;
    logic                  is_load;
    logic                  is_store;
    logic                  is_mul;

    // the stage never stalls on its own, so it only waits for MEM
    assign in_allowin       = ~exe_valid | mem_allowin;
    assign exe_to_mem_valid = exe_valid;
    assign exe_go           = exe_valid & mem_allowin;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_valid <= 1'b0;
        end else if (in_allowin) begin
            exe_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            op_r   <= in_op;
            exe_pc <= in_pc;
            exe_rd <= in_rd;
            src1_r <= in_src1;
            src2_r <= in_src2;
            imm_r  <= in_imm;
        end
    end

    assign sum  = src1_r + src2_r;
    assign addr = src1_r + imm_r;

    always_comb begin
        exe_load_kind  = ld_none;
        exe_result_src = src_alu;
        exe_we         = 1'b1;
        is_store       = 1'b0;
        is_mul         = 1'b0;
        case (op_r)
            op_ld_b:  exe_load_kind = ld_b;
            op_ld_bu: exe_load_kind = ld_bu;
            op_ld_h:  exe_load_kind = ld_h;
            op_ld_hu: exe_load_kind = ld_hu;
            op_ld_w:  exe_load_kind = ld_w;
            op_st_w: begin
                exe_we   = 1'b0;
                is_store = 1'b1;
            end
            op_mul_lo: begin
                exe_result_src = src_mul_lo;
                is_mul         = 1'b1;
            end
            op_mul_hi: begin
                exe_result_src = src_mul_hi;
                is_mul         = 1'b1;
            end
            default: ;
        endcase
        if (exe_load_kind != ld_none) begin
            exe_result_src = src_mem;
        end
    end

    assign is_load = (exe_load_kind != ld_none);

    // MEM needs the byte offset of a load, so loads and stores carry the address
    assign exe_alu_result = (op_r == op_add) ? sum : addr;

    // RAM and multiplier are only touched on the transfer into MEM
    assign ram_en    = exe_go & (is_load | is_store);
    assign ram_we    = exe_go & is_store;
    assign ram_addr  = addr[ram_addr_width+1:2];
    assign ram_wdata = src2_r;

    assign mul_en = exe_go & is_mul;
    assign mul_a  = src1_r;
    assign mul_b  = src2_r;

endmodule

`default_nettype wire

/* source/mul_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_unit (
    input  logic                                  clk,
    input  logic                                  mul_en,
    input  logic [mem_pipe_pkg::data_width-1:0]   mul_a,
    input  logic [mem_pipe_pkg::data_width-1:0]   mul_b,
    output logic [2*mem_pipe_pkg::data_width-1:0] mul_product
);
    import mem_pipe_pkg::*;

    logic signed [data_width-1:0]   a_s;
    logic signed [data_width-1:0]   b_s;
    logic signed [2*data_width-1:0] product;

    assign a_s = mul_a;
    assign b_s = mul_b;

    // both operands are signed and the target is full width, so the
    // multiply sign-extends to 64 bits before it is evaluated
    assign product = a_s * b_s;

    // the product register only moves with an EX-to-MEM transfer, so it
    // stays matched to the instruction in MEM while that one waits
    always_ff @(posedge clk) begin
        if (mul_en) begin
            mul_product <= product;
        end
    end

endmodule

`default_nettype wire

/* source/mem_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_stage (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic                                  exe_to_mem_valid,
    input  logic [mem_pipe_pkg::data_width-1:0]   exe_pc,
    input  logic [4:0]                            exe_rd,
    input  logic                                  exe_we,
    input  logic [mem_pipe_pkg::data_width-1:0]   exe_alu_result,
    input  mem_pipe_pkg::load_kind_e              exe_load_kind,
    input  mem_pipe_pkg::result_src_e             exe_result_src,
    output logic                                  mem_allowin,
    input  logic                                  wb_allowin,
    output logic                                  mem_to_wb_valid,
    output logic [mem_pipe_pkg::data_width-1:0]   mem_pc,
    output logic [4:0]                            mem_rd,
    output logic                                  mem_we,
    output logic [mem_pipe_pkg::data_width-1:0]   mem_wdata,
    input  logic [mem_pipe_pkg::data_width-1:0]   ram_rdata,
    input  logic [2*mem_pipe_pkg::data_width-1:0] mul_product
);
    import mem_pipe_pkg::*;

    logic                  mem_valid;
    logic [data_width-1:0] alu_result_r;
    load_kind_e            load_kind_r;
    result_src_e           result_src_r;
    logic [data_width-1:0] shift_rdata;
    logic [data_width-1:0] load_data;

    // RAM data is already here, so MEM is always ready to go
    assign mem_allowin     = ~mem_valid | wb_allowin;
    assign mem_to_wb_valid = mem_valid;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (mem_allowin) begin
            mem_valid <= exe_to_mem_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_to_mem_valid && mem_allowin) begin
            mem_pc       <= exe_pc;
            mem_rd       <= exe_rd;
            mem_we       <= exe_we;
            alu_result_r <= exe_alu_result;
            load_kind_r  <= exe_load_kind;
            result_src_r <= exe_result_src;
        end
    end

    // move the addressed byte or halfword down to bit 0
    assign shift_rdata = ram_rdata >> {alu_result_r[1:0], 3'b000};

    always_comb begin
        case (load_kind_r)
            ld_b:    load_data = {{24{shift_rdata[7]}}, shift_rdata[7:0]};
            ld_bu:   load_data = {24'b0, shift_rdata[7:0]};
            ld_h:    load_data = {{16{shift_rdata[15]}}, shift_rdata[15:0]};
            ld_hu:   load_data = {16'b0, shift_rdata[15:0]};
            default: load_data = shift_rdata;
        endcase
    end

    always_comb begin
        case (result_src_r)
            src_mem:    mem_wdata = load_data;
            src_mul_lo: mem_wdata = mul_product[data_width-1:0];
            src_mul_hi: mem_wdata = mul_product[2*data_width-1:data_width];
            default:    mem_wdata = alu_result_r;
        endcase
    end

endmodule

`default_nettype wire

/* source/wb_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module wb_stage (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                mem_to_wb_valid,
    input  logic [mem_pipe_pkg::data_width-1:0] mem_pc,
    input  logic [4:0]                          mem_rd,
    input  logic                                mem_we,
    input  logic [mem_pipe_pkg::data_width-1:0] mem_wdata,
    output logic                                wb_allowin,
    input  logic                                retire_ready,
    output logic                                retire_valid,
    output logic [mem_pipe_pkg::data_width-1:0] retire_pc,
    output logic                                retire_we,
    output logic [4:0]                          retire_rd,
    output logic [mem_pipe_pkg::data_width-1:0] retire_wdata
);

    // a retired instruction leaves when the consumer takes it
    assign wb_allowin = ~retire_valid | retire_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            retire_valid <= 1'b0;
        end else if (wb_allowin) begin
            retire_valid <= mem_to_wb_valid;
        end
    end

    // outputs hold while the consumer stalls
    always_ff @(posedge clk) begin
        if (mem_to_wb_valid && wb_allowin) begin
            retire_pc    <= mem_pc;
            retire_we    <= mem_we;
            retire_rd    <= mem_rd;
            retire_wdata <= mem_wdata;
        end
    end

endmodule

`default_nettype wire

/* source/data_ram.sv */
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
    parameter int ram_addr_width = 8
) (
    input  logic                                clk,
    input  logic                                ram_en,
    input  logic                                ram_we,
    input  logic [ram_addr_width-1:0]           ram_addr,
    input  logic [mem_pipe_pkg::data_width-1:0] ram_wdata,
    output logic [mem_pipe_pkg::data_width-1:0] ram_rdata
);
    import mem_pipe_pkg::*;

    localparam int unsigned depth = 2 ** ram_addr_width;

    logic [data_width-1:0] mem [0:depth-1];

    // single port, a write leaves the read register untouched
    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end else begin
                ram_rdata <= mem[ram_addr];
            end
        end
    end

endmodule

`default_nettype wire

/* source/mem_pipe_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_pipe_top #(
    parameter int ram_addr_width = 8
) (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                in_valid,
    input  mem_pipe_pkg::exe_op_e               in_op,
    input  logic [mem_pipe_pkg::data_width-1:0] in_pc,
    input  logic [4:0]                          in_rd,
    input  logic [mem_pipe_pkg::data_width-1:0] in_src1,
    input  logic [mem_pipe_pkg::data_width-1:0] in_src2,
    input  logic [mem_pipe_pkg::data_width-1:0] in_imm,
    output logic                                in_allowin,
    output logic                                retire_valid,
    output logic [mem_pipe_pkg::data_width-1:0] retire_pc,
    output logic                                retire_we,
    output logic [4:0]                          retire_rd,
    output logic [mem_pipe_pkg::data_width-1:0] retire_wdata,
    input  logic                                retire_ready
);
    import mem_pipe_pkg::*;

    logic                    mem_allowin;
    logic                    wb_allowin;
    logic                    exe_to_mem_valid;
    logic [data_width-1:0]   exe_pc;
    logic [4:0]              exe_rd;
    logic                    exe_we;
    logic [data_width-1:0]   exe_alu_result;
    load_kind_e              exe_load_kind;
    result_src_e             exe_result_src;
    logic                    mem_to_wb_valid;
    logic [data_width-1:0]   mem_pc;
    logic [4:0]              mem_rd;
    logic                    mem_we;
    logic [data_width-1:0]   mem_wdata;
    logic                    ram_en;
    logic                    ram_we;
    logic [ram_addr_width-1:0] ram_addr;
    logic [data_width-1:0]   ram_wdata;
    logic [data_width-1:0]   ram_rdata;
    logic                    mul_en;
    logic [data_width-1:0]   mul_a;
    logic [data_width-1:0]   mul_b;
    logic [2*data_width-1:0] mul_product;

    exe_stage #(.ram_addr_width(ram_addr_width)) u_exe_stage (
        .clk, .resetn,
        .in_valid, .in_op, .in_pc, .in_rd, .in_src1, .in_src2, .in_imm,
        .in_allowin, .mem_allowin,
        .exe_to_mem_valid, .exe_pc, .exe_rd, .exe_we, .exe_alu_result,
        .exe_load_kind, .exe_result_src,
        .ram_en, .ram_we, .ram_addr, .ram_wdata,
        .mul_en, .mul_a, .mul_b
    );

    mul_unit u_mul_unit (
        .clk, .mul_en, .mul_a, .mul_b, .mul_product
    );

    data_ram #(.ram_addr_width(ram_addr_width)) u_data_ram (
        .clk, .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    mem_stage u_mem_stage (
        .clk, .resetn,
        .exe_to_mem_valid, .exe_pc, .exe_rd, .exe_we, .exe_alu_result,
        .exe_load_kind, .exe_result_src,
        .mem_allowin, .wb_allowin,
        .mem_to_wb_valid, .mem_pc, .mem_rd, .mem_we, .mem_wdata,
        .ram_rdata, .mul_product
    );

    wb_stage u_wb_stage (
        .clk, .resetn,
        .mem_to_wb_valid, .mem_pc, .mem_rd, .mem_we, .mem_wdata,
        .wb_allowin, .retire_ready,
        .retire_valid, .retire_pc, .retire_we, .retire_rd, .retire_wdata
    );

endmodule

`default_nettype wire

/* verification/mem_pipe_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_pipe_assertions (
    input wire        clk,
    input wire        resetn,
    input wire        retire_valid,
    input wire        retire_ready,
    input wire [31:0] retire_pc,
    input wire        retire_we,
    input wire [4:0]  retire_rd,
    input wire [31:0] retire_wdata,
    input wire        ram_en,
    input wire        mul_en,
    input wire        mem_to_wb_valid,
    input wire        wb_allowin
);

    int error_count = 0;

    // reset is synchronous, so the valid bits are clear one edge later
    a_reset_clears: assert property (@(posedge clk)
        !resetn |=> !retire_valid && !ram_en && !mul_en)
        else begin
            $error("a valid output is high after a reset edge");
            error_count++;
        end

    a_retire_hold: assert property (@(posedge clk) disable iff (!resetn)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire_pc)
            && $stable(retire_we) && $stable(retire_rd) && $stable(retire_wdata))
        else begin
            $error("retire port changed while the consumer was stalling");
            error_count++;
        end

    // a stalled MEM instruction still needs its RAM word and product, so nothing leaves EX
    a_ram_held_in_mem: assert property (@(posedge clk) disable iff (!resetn)
        mem_to_wb_valid && !wb_allowin |-> !ram_en)
        else begin
            $error("ram_en high while MEM held a stalled instruction");
            error_count++;
        end

    a_mul_held_in_mem: assert property (@(posedge clk) disable iff (!resetn)
        mem_to_wb_valid && !wb_allowin |-> !mul_en)
        else begin
            $error("mul_en high while MEM held a stalled instruction");
            error_count++;
        end

endmodule

bind mem_pipe_top mem_pipe_assertions u_assertions (
    .clk(clk), .resetn(resetn),
    .retire_valid(retire_valid), .retire_ready(retire_ready),
    .retire_pc(retire_pc), .retire_we(retire_we), .retire_rd(retire_rd),
    .retire_wdata(retire_wdata),
    .ram_en(ram_en), .mul_en(mul_en),
    .mem_to_wb_valid(mem_to_wb_valid), .wb_allowin(wb_allowin)
);

`default_nettype wire

/* verification/mem_pipe_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_pipe_tb;
    import mem_pipe_pkg::*;

    localparam int clk_period  = 100;
    localparam int ram_aw      = 8;
    localparam int max_entries = 48;

    logic        clk = 1'b0;
    logic        resetn;
    logic        in_valid;
    exe_op_e     in_op;
    logic [31:0] in_pc;
    logic [4:0]  in_rd;
    logic [31:0] in_src1;
    logic [31:0] in_src2;
    logic [31:0] in_imm;
    logic        in_allowin;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_wdata;
    logic        retire_ready;

    // instruction table, filled once at time zero
    string       tbl_name [max_entries];
    exe_op_e     tbl_op   [max_entries];
    logic [31:0] tbl_pc   [max_entries];
    logic [4:0]  tbl_rd   [max_entries];
    logic [31:0] tbl_src1 [max_entries];
    logic [31:0] tbl_src2 [max_entries];
    logic [31:0] tbl_imm  [max_entries];
    logic        exp_we   [max_entries];
    logic [31:0] exp_data [max_entries];
    int          num_entries   = 0;
    int          retired_count = 0;
    int          pending_q [$];
    logic [31:0] model_mem [0:(1 << ram_aw) - 1];
    integer      seed;

    mem_pipe_top #(.ram_addr_width(ram_aw)) UUT (
        .clk(clk), .resetn(resetn),
        .in_valid(in_valid), .in_op(in_op), .in_pc(in_pc), .in_rd(in_rd),
        .in_src1(in_src1), .in_src2(in_src2), .in_imm(in_imm),
        .in_allowin(in_allowin),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_we(retire_we),
        .retire_rd(retire_rd), .retire_wdata(retire_wdata),
        .retire_ready(retire_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic add_entry(input string name, input exe_op_e op, input logic [4:0] rd,
                             input logic [31:0] src1, input logic [31:0] src2,
                             input logic [31:0] imm);
        tbl_name[num_entries] = name;
        tbl_op[num_entries]   = op;
        tbl_pc[num_entries]   = 32'h0000_1000 + 4 * num_entries;
        tbl_rd[num_entries]   = rd;
        tbl_src1[num_entries] = src1;
        tbl_src2[num_entries] = src2;
        tbl_imm[num_entries]  = imm;
        num_entries++;
    endtask

    task automatic build_table();
        add_entry("add_small", op_add, 5'd1, 32'd5, 32'd7, 32'd0);
        add_entry("add_wrap", op_add, 5'd2, 32'hffff_fff0, 32'h0000_0020, 32'd0);
        add_entry("add_carry_out", op_add, 5'd3, 32'h8000_0000, 32'h8000_0000, 32'd0);
        add_entry("st_w_word0", op_st_w, 5'd0, 32'h0000_00f0, 32'h8765_43f1, 32'h10);
        add_entry("st_w_word1", op_st_w, 5'd0, 32'h0000_0100, 32'h1234_5678, 32'h4);
        add_entry("st_w_word2", op_st_w, 5'd0, 32'h0000_0108, 32'hf00d_9abc, 32'h0);
        for (int off = 0; off < 4; off++) begin
            add_entry($sformatf("ld_b_off%0d", off), op_ld_b, 5'(8 + off),
                      32'h0000_0100, 32'd0, off);
            add_entry($sformatf("ld_bu_off%0d", off), op_ld_bu, 5'(12 + off),
                      32'h0000_0100, 32'd0, off);
            add_entry($sformatf("ld_h_off%0d", off), op_ld_h, 5'(16 + off),
                      32'h0000_0100, 32'd0, 8 + off);
            add_entry($sformatf("ld_hu_off%0d", off), op_ld_hu, 5'(20 + off),
                      32'h0000_0100, 32'd0, 8 + off);
        end
        add_entry("ld_w_word1", op_ld_w, 5'd24, 32'h0000_0104, 32'd0, 32'd0);
        // the loads right behind this store must see the new word
        add_entry("st_w_last_word", op_st_w, 5'd0, 32'h0000_03f0, 32'hc0de_7e57, 32'hc);
        add_entry("ld_w_after_st", op_ld_w, 5'd25, 32'h0000_03f0, 32'd0, 32'hc);
        add_entry("ld_hu_after_st", op_ld_hu, 5'd26, 32'h0000_03f0, 32'd0, 32'he);
        add_entry("ld_b_after_st", op_ld_b, 5'd27, 32'h0000_03f0, 32'd0, 32'hd);
        add_entry("mul_lo_pos_neg", op_mul_lo, 5'd28, 32'd3, -32'sd5, 32'd0);
        add_entry("mul_hi_pos_neg", op_mul_hi, 5'd29, 32'd3, -32'sd5, 32'd0);
        add_entry("mul_lo_neg_neg", op_mul_lo, 5'd30, -32'sd7, -32'sd9, 32'd0);
        add_entry("mul_hi_neg_neg", op_mul_hi, 5'd31, -32'sd7, -32'sd9, 32'd0);
        add_entry("mul_lo_max", op_mul_lo, 5'd4, 32'h7fff_ffff, 32'h7fff_ffff, 32'd0);
        add_entry("mul_hi_max", op_mul_hi, 5'd5, 32'h7fff_ffff, 32'h7fff_ffff, 32'd0);
        add_entry("mul_lo_min", op_mul_lo, 5'd6, 32'h8000_0000, 32'h8000_0000, 32'd0);
        add_entry("mul_hi_min", op_mul_hi, 5'd7, 32'h8000_0000, 32'h8000_0000, 32'd0);
    endtask

    function automatic logic [63:0] signed_product(input logic [31:0] a, input logic [31:0] b);
        logic signed [63:0] a_w;
        logic signed [63:0] b_w;
        a_w = {{32{a[31]}}, a};
        b_w = {{32{b[31]}}, b};
        return a_w * b_w;
    endfunction

    function automatic logic [31:0] expected_load(input exe_op_e op, input logic [31:0] word,
                                                  input logic [1:0] off);
        logic [63:0] wide;
        logic [7:0]  b;
        logic [15:0] h;
        wide = {32'h0, word} >> (8 * off);
        b    = wide[7:0];
        h    = wide[15:0];
        case (op)
            op_ld_b:  return {{24{b[7]}}, b};
            op_ld_bu: return {24'h0, b};
            op_ld_h:  return {{16{h[15]}}, h};
            op_ld_hu: return {16'h0, h};
            default:  return word;
        endcase
    endfunction

    // reference model, run in issue order so stores update memory before later loads
    task automatic model_issue(input int i);
        logic [31:0] addr;
        logic [63:0] prod;
        addr        = tbl_src1[i] + tbl_imm[i];
        exp_we[i]   = 1'b1;
        exp_data[i] = '0;
        case (tbl_op[i])
            op_add: exp_data[i] = tbl_src1[i] + tbl_src2[i];
            op_st_w: begin
                model_mem[addr[ram_aw+1:2]] = tbl_src2[i];
                exp_we[i] = 1'b0;
            end
            op_mul_lo, op_mul_hi: begin
                prod        = signed_product(tbl_src1[i], tbl_src2[i]);
                exp_data[i] = (tbl_op[i] == op_mul_hi) ? prod[63:32] : prod[31:0];
            end
            default: begin
                exp_data[i] = expected_load(tbl_op[i], model_mem[addr[ram_aw+1:2]], addr[1:0]);
            end
        endcase
        pending_q.push_back(i);
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input logic [31:0] expected, input logic [31:0] actual);
        $display("[ERROR] %s: %s expected %h, actual %h", name, field, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1, "retired instruction does not match the model");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped on a failure");
    endtask

    task automatic check_retire();
        int idx;
        assert (pending_q.size() != 0)
            else report_failure("an instruction retired although none was outstanding");
        idx = pending_q.pop_front();
        assert (retire_pc == tbl_pc[idx])
            else report_mismatch(tbl_name[idx], "pc", tbl_pc[idx], retire_pc);
        assert (retire_we == exp_we[idx])
            else report_mismatch(tbl_name[idx], "we", 32'(exp_we[idx]), 32'(retire_we));
        assert (retire_rd == tbl_rd[idx])
            else report_mismatch(tbl_name[idx], "rd", 32'(tbl_rd[idx]), 32'(retire_rd));
        // a store writes no register, so its data is not compared
        if (exp_we[idx]) begin
            assert (retire_wdata == exp_data[idx])
                else report_mismatch(tbl_name[idx], "wdata", exp_data[idx], retire_wdata);
        end
        retired_count++;
    endtask

    initial begin : stimulus
        resetn   = 1'b0;
        in_valid = 1'b0;
        in_op    = op_add;
        in_pc    = '0;
        in_rd    = '0;
        in_src1  = '0;
        in_src2  = '0;
        in_imm   = '0;
        build_table();
        repeat (16) @(negedge clk);
        resetn = 1'b1;
        assert (retire_valid == 1'b0)
            else report_failure("retire_valid is high right after reset");
        // idle cycles before the first issue
        repeat (3) begin
            @(negedge clk);
            assert (retire_valid == 1'b0)
                else report_failure("retire_valid went high before any instruction was issued");
        end
        for (int i = 0; i < num_entries; i++) begin
            @(negedge clk);
            in_valid = 1'b1;
            in_op    = tbl_op[i];
            in_pc    = tbl_pc[i];
            in_rd    = tbl_rd[i];
            in_src1  = tbl_src1[i];
            in_src2  = tbl_src2[i];
            in_imm   = tbl_imm[i];
            #(clk_period / 4);
            while (!in_allowin) begin
                @(negedge clk);
                #(clk_period / 4);
            end
            model_issue(i);
        end
        @(negedge clk);
        in_valid = 1'b0;
        wait (retired_count == num_entries);
        repeat (8) @(negedge clk);
        if (pending_q.size() == 0 && UUT.u_assertions.error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Pipeline control assertions failed during the run");
            $display("SOME TESTS FAILED");
            $fatal(1, "run ended with failures");
        end
    end

    // back-pressure on the retire port, sampled a quarter period after the falling edge
    initial begin : retire_side
        retire_ready = 1'b0;
        seed         = 32'hb0fd_6314;
        wait (resetn === 1'b1);
        forever begin
            @(negedge clk);
            retire_ready = (($random(seed) & 3) != 0);
            #(clk_period / 4);
            if (retire_valid && retire_ready) begin
                check_retire();
            end
        end
    end

    initial begin : assertion_monitor
        wait (UUT.u_assertions.error_count != 0);
        report_failure("a pipeline control assertion failed");
    end

    initial begin : watchdog
        wait (resetn === 1'b1);
        repeat (num_entries * 20) @(posedge clk);
        $display("Timeout: not every instruction retired within the expected time");
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

/* mem_pipe_top.f */
source/mem_pipe_pkg.sv
source/exe_stage.sv
source/mul_unit.sv
source/mem_stage.sv
source/wb_stage.sv
source/data_ram.sv
source/mem_pipe_top.sv
verification/mem_pipe_assertions.sv
verification/mem_pipe_tb.sv

/* Bender.yml */
package:
  name: mem_pipe

sources:
  - files:
      - source/mem_pipe_pkg.sv
      - source/exe_stage.sv
      - source/mul_unit.sv
      - source/mem_stage.sv
      - source/wb_stage.sv
      - source/data_ram.sv
      - source/mem_pipe_top.sv
  - target: test
    files:
      - verification/mem_pipe_assertions.sv
      - verification/mem_pipe_tb.sv
